/* Makefile */
VERILATOR ?= verilator
TOP       ?= lsu_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/lsu_pkg.sv */
package lsu_pkg;

    localparam int LOAD_PIPES  = 2;
    localparam int STORE_PIPES = 2;
    localparam int ADDR_W      = 32;
    localparam int MASK_W      = 4;
    localparam int LQ_W        = 4;
    localparam int ROB_W       = 6;
    localparam int RD_W        = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [MASK_W-1:0] mask_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    // wrap bit flips each time the index rolls over
    typedef struct packed {
        logic            wrap;
        logic [LQ_W-1:0] idx;
    } lq_idx_t;

    typedef struct packed {
        logic             wrap;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        addr_t           base;
        addr_t           imm;
        mem_size_t       size;
        lq_idx_t         lq_idx;
        rob_idx_t        rob_idx;
        logic [RD_W-1:0] rd;
    } load_issue_t;

    // lq_idx is the slot of the first load younger than the store
    typedef struct packed {
        addr_t     base;
        addr_t     imm;
        mem_size_t size;
        lq_idx_t   lq_idx;
        rob_idx_t  rob_idx;
    } store_issue_t;

    typedef struct packed {
        addr_t           addr;
        mask_t           mask;
        lq_idx_t         lq_idx;
        rob_idx_t        rob_idx;
        logic [RD_W-1:0] rd;
    } load_enq_t;

    typedef struct packed {
        addr_t    addr;
        mask_t    mask;
        rob_idx_t rob_idx;
    } store_enq_t;

    typedef struct packed {
        logic     valid;
        addr_t    addr;
        mask_t    mask;
        lq_idx_t  lq_idx;
        rob_idx_t rob_idx;
    } viol_rec_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } redirect_t;

    // true when a is strictly older than b
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        return (a.wrap == b.wrap) ? (a.idx < b.idx) : (a.idx > b.idx);
    endfunction

    function automatic logic lq_older(lq_idx_t a, lq_idx_t b);
        return (a.wrap == b.wrap) ? (a.idx < b.idx) : (a.idx > b.idx);
    endfunction

endpackage

/* load_pipe/load_pipe.sv */
`timescale 1ns/1ns

module load_pipe (
    input  logic                                       clk,
    input  logic                                       arst_n_i,
    input  logic        [lsu_pkg::LOAD_PIPES-1:0]      valid_i,
    input  lsu_pkg::load_issue_t [lsu_pkg::LOAD_PIPES-1:0] issue_i,
    input  lsu_pkg::redirect_t                         redirect_i,
    output logic        [lsu_pkg::LOAD_PIPES-1:0]      enq_valid_o,
    output lsu_pkg::load_enq_t [lsu_pkg::LOAD_PIPES-1:0] enq_o,
    output lsu_pkg::viol_rec_t [lsu_pkg::LOAD_PIPES-1:0] s1_rec_o,
    output lsu_pkg::viol_rec_t [lsu_pkg::LOAD_PIPES-1:0] s2_rec_o
);
    import lsu_pkg::*;

    addr_t     [LOAD_PIPES-1:0] s0_addr;
    mask_t     [LOAD_PIPES-1:0] s0_mask;
    logic      [LOAD_PIPES-1:0] s0_kill;
    load_enq_t [LOAD_PIPES-1:0] s0_rec;

    logic      [LOAD_PIPES-1:0] s1_valid;
    logic      [LOAD_PIPES-1:0] s1_kill;
    load_enq_t [LOAD_PIPES-1:0] s1_q;

    logic      [LOAD_PIPES-1:0] s2_valid;
    logic      [LOAD_PIPES-1:0] s2_kill;
    load_enq_t [LOAD_PIPES-1:0] s2_q;

    for (genvar i = 0; i < LOAD_PIPES; i++) begin : g_agu
        addr_gen u_addr_gen (
            .base_i (issue_i[i].base),
            .imm_i  (issue_i[i].imm),
            .size_i (issue_i[i].size),
            .addr_o (s0_addr[i]),
            .mask_o (s0_mask[i])
        );
    end

    // flush anything younger than the redirect, in every stage
    always_comb begin
        for (int i = 0; i < LOAD_PIPES; i++) begin
            s0_kill[i] = redirect_i.valid && rob_older(redirect_i.rob_idx, issue_i[i].rob_idx);
            s1_kill[i] = redirect_i.valid && rob_older(redirect_i.rob_idx, s1_q[i].rob_idx);
            s2_kill[i] = redirect_i.valid && rob_older(redirect_i.rob_idx, s2_q[i].rob_idx);

            s0_rec[i].addr    = s0_addr[i];
            s0_rec[i].mask    = s0_mask[i];
            s0_rec[i].lq_idx  = issue_i[i].lq_idx;
            s0_rec[i].rob_idx = issue_i[i].rob_idx;
            s0_rec[i].rd      = issue_i[i].rd;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid <= '0;
            s2_valid <= '0;
        end else begin
            s1_valid <= valid_i & ~s0_kill;
            s2_valid <= s1_valid & ~s1_kill;
        end
    end

    always_ff @(posedge clk) begin
        s1_q <= s0_rec;
        s2_q <= s1_q;
    end

    assign enq_valid_o = s2_valid & ~s2_kill;
    assign enq_o       = s2_q;

    // records seen by the violation check, before this stage's flush
    always_comb begin
        for (int i = 0; i < LOAD_PIPES; i++) begin
            s1_rec_o[i].valid   = s1_valid[i];
            s1_rec_o[i].addr    = s1_q[i].addr;
            s1_rec_o[i].mask    = s1_q[i].mask;
            s1_rec_o[i].lq_idx  = s1_q[i].lq_idx;
            s1_rec_o[i].rob_idx = s1_q[i].rob_idx;

            s2_rec_o[i].valid   = s2_valid[i];
            s2_rec_o[i].addr    = s2_q[i].addr;
            s2_rec_o[i].mask    = s2_q[i].mask;
            s2_rec_o[i].lq_idx  = s2_q[i].lq_idx;
            s2_rec_o[i].rob_idx = s2_q[i].rob_idx;
        end
    end

endmodule

/* sim.f */
common/lsu_pkg.sv
source/addr_gen.sv
load_pipe/load_pipe.sv
store_pipe/store_pipe.sv
violation/violation_check.sv
source/lsu_top.sv
tests/tb_clock.sv
tests/lsu_tb.sv

/* source/addr_gen.sv */
`timescale 1ns/1ns

module addr_gen (
    input  lsu_pkg::addr_t     base_i,
    input  lsu_pkg::addr_t     imm_i,
    input  lsu_pkg::mem_size_t size_i,
    output lsu_pkg::addr_t     addr_o,
    output lsu_pkg::mask_t     mask_o
);
    import lsu_pkg::*;

    logic [1:0] offset;

    assign addr_o = base_i + imm_i;
    assign offset = addr_o[1:0];

    always_comb begin
        case (size_i)
            MEM_WORD: begin
                mask_o = 4'b1111;
            end
            MEM_HALF: begin
                // a half at offset 3 keeps only the top byte
                if (offset == 2'd3) begin
                    mask_o = 4'b1000;
                end else begin
                    mask_o = mask_t'(4'b0011 << offset);
                end
            end
            default: begin
                mask_o = mask_t'(4'b0001 << offset);
            end
        endcase
    end

endmodule

/* source/lsu_top.sv */
`timescale 1ns/1ns

module lsu_top (
    input  logic                                           clk,
    input  logic                                           arst_n_i,
    input  logic        [lsu_pkg::LOAD_PIPES-1:0]          load_valid_i,
    input  lsu_pkg::load_issue_t [lsu_pkg::LOAD_PIPES-1:0] load_issue_i,
    input  logic        [lsu_pkg::STORE_PIPES-1:0]         store_valid_i,
    input  lsu_pkg::store_issue_t [lsu_pkg::STORE_PIPES-1:0] store_issue_i,
    input  lsu_pkg::redirect_t                             redirect_i,
    output logic        [lsu_pkg::LOAD_PIPES-1:0]          load_enq_valid_o,
    output lsu_pkg::load_enq_t [lsu_pkg::LOAD_PIPES-1:0]   load_enq_o,
    output logic        [lsu_pkg::STORE_PIPES-1:0]         store_enq_valid_o,
    output lsu_pkg::store_enq_t [lsu_pkg::STORE_PIPES-1:0] store_enq_o,
    output logic        [lsu_pkg::STORE_PIPES-1:0]         store_wb_valid_o,
    output lsu_pkg::rob_idx_t [lsu_pkg::STORE_PIPES-1:0]   store_wb_rob_o,
    output lsu_pkg::redirect_t                             mem_redirect_o
);
    import lsu_pkg::*;

    viol_rec_t [LOAD_PIPES-1:0]  load_s1_rec;
    viol_rec_t [LOAD_PIPES-1:0]  load_s2_rec;
    viol_rec_t [STORE_PIPES-1:0] store_s1_rec;

    load_pipe u_load_pipe (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (load_valid_i),
        .issue_i     (load_issue_i),
        .redirect_i  (redirect_i),
        .enq_valid_o (load_enq_valid_o),
        .enq_o       (load_enq_o),
        .s1_rec_o    (load_s1_rec),
        .s2_rec_o    (load_s2_rec)
    );

    store_pipe u_store_pipe (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .valid_i     (store_valid_i),
        .issue_i     (store_issue_i),
        .redirect_i  (redirect_i),
        .enq_valid_o (store_enq_valid_o),
        .enq_o       (store_enq_o),
        .wb_valid_o  (store_wb_valid_o),
        .wb_rob_o    (store_wb_rob_o),
        .s1_rec_o    (store_s1_rec)
    );

    violation_check u_violation_check (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .store_rec_i    (store_s1_rec),
        .load_s1_rec_i  (load_s1_rec),
        .load_s2_rec_i  (load_s2_rec),
        .mem_redirect_o (mem_redirect_o)
    );

endmodule

/* store_pipe/store_pipe.sv */
`timescale 1ns/1ns

module store_pipe (
    input  logic                                          clk,
    input  logic                                          arst_n_i,
    input  logic        [lsu_pkg::STORE_PIPES-1:0]        valid_i,
    input  lsu_pkg::store_issue_t [lsu_pkg::STORE_PIPES-1:0] issue_i,
    input  lsu_pkg::redirect_t                            redirect_i,
    output logic        [lsu_pkg::STORE_PIPES-1:0]        enq_valid_o,
    output lsu_pkg::store_enq_t [lsu_pkg::STORE_PIPES-1:0] enq_o,
    output logic        [lsu_pkg::STORE_PIPES-1:0]        wb_valid_o,
    output lsu_pkg::rob_idx_t [lsu_pkg::STORE_PIPES-1:0]  wb_rob_o,
    output lsu_pkg::viol_rec_t [lsu_pkg::STORE_PIPES-1:0] s1_rec_o
);
    import lsu_pkg::*;

    addr_t      [STORE_PIPES-1:0] s0_addr;
    mask_t      [STORE_PIPES-1:0] s0_mask;
    logic       [STORE_PIPES-1:0] s0_kill;

    logic       [STORE_PIPES-1:0] s1_valid;
    logic       [STORE_PIPES-1:0] s1_kill;
    store_enq_t [STORE_PIPES-1:0] s1_q;
    lq_idx_t    [STORE_PIPES-1:0] s1_lq;

    logic       [STORE_PIPES-1:0] wb_valid_q;
    rob_idx_t   [STORE_PIPES-1:0] wb_rob_q;

    for (genvar i = 0; i < STORE_PIPES; i++) begin : g_agu
        addr_gen u_addr_gen (
            .base_i (issue_i[i].base),
            .imm_i  (issue_i[i].imm),
            .size_i (issue_i[i].size),
            .addr_o (s0_addr[i]),
            .mask_o (s0_mask[i])
        );
    end

    always_comb begin
        for (int i = 0; i < STORE_PIPES; i++) begin
            s0_kill[i] = redirect_i.valid && rob_older(redirect_i.rob_idx, issue_i[i].rob_idx);
            s1_kill[i] = redirect_i.valid && rob_older(redirect_i.rob_idx, s1_q[i].rob_idx);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid   <= '0;
            wb_valid_q <= '0;
        end else begin
            s1_valid   <= valid_i & ~s0_kill;
            wb_valid_q <= enq_valid_o;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < STORE_PIPES; i++) begin
            s1_q[i].addr    <= s0_addr[i];
            s1_q[i].mask    <= s0_mask[i];
            s1_q[i].rob_idx <= issue_i[i].rob_idx;
            s1_lq[i]        <= issue_i[i].lq_idx;
            wb_rob_q[i]     <= s1_q[i].rob_idx;
        end
    end

    // handed to the store queue in S1, written back one cycle later
    assign enq_valid_o = s1_valid & ~s1_kill;
    assign enq_o       = s1_q;
    assign wb_valid_o  = wb_valid_q;
    assign wb_rob_o    = wb_rob_q;

    always_comb begin
        for (int i = 0; i < STORE_PIPES; i++) begin
            s1_rec_o[i].valid   = s1_valid[i];
            s1_rec_o[i].addr    = s1_q[i].addr;
            s1_rec_o[i].mask    = s1_q[i].mask;
            s1_rec_o[i].lq_idx  = s1_lq[i];
            s1_rec_o[i].rob_idx = s1_q[i].rob_idx;
        end
    end

endmodule

/* tests/lsu_tb.sv */
`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam int N_RAND = 40;
    localparam int WATCHDOG_CYCLES = 2 * N_RAND + 160;

    logic clk;
    logic arst_n_i;
    logic [1:0] load_valid_i;
    load_issue_t [1:0] load_issue_i;
    logic [1:0] store_valid_i;
    store_issue_t [1:0] store_issue_i;
    redirect_t redirect_i;
    logic [1:0] load_enq_valid_o;
    load_enq_t [1:0] load_enq_o;
    logic [1:0] store_enq_valid_o;
    store_enq_t [1:0] store_enq_o;
    logic [1:0] store_wb_valid_o;
    rob_idx_t [1:0] store_wb_rob_o;
    redirect_t mem_redirect_o;

    logic [31:0] lfsr = 32'd87360;
    int errors = 0;
    int seq_errors = 0;
    int checks = 0;
    int red_seen = 0;
    int tests_run = 0;
    int tests_failed = 0;

    // model state with one entry per lane and stage
    logic [1:0] m_ld1_v;
    logic [1:0] m_ld2_v;
    load_enq_t [1:0] m_ld1;
    load_enq_t [1:0] m_ld2;
    logic [1:0] m_st1_v;
    store_enq_t [1:0] m_st1;
    lq_idx_t [1:0] m_st1_lq;
    logic [1:0] m_wb_v;
    rob_idx_t [1:0] m_wb_rob;
    redirect_t m_red0;
    redirect_t m_red1;
    load_enq_t cand;
    logic cand_v;
    logic best_v;
    lq_idx_t best_lq;
    rob_idx_t best_rob;

    tb_clock u_clock (
        .clk_o    (clk),
        .arst_n_o (arst_n_i)
    );

    lsu_top uut (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .load_valid_i      (load_valid_i),
        .load_issue_i      (load_issue_i),
        .store_valid_i     (store_valid_i),
        .store_issue_i     (store_issue_i),
        .redirect_i        (redirect_i),
        .load_enq_valid_o  (load_enq_valid_o),
        .load_enq_o        (load_enq_o),
        .store_enq_valid_o (store_enq_valid_o),
        .store_enq_o       (store_enq_o),
        .store_wb_valid_o  (store_wb_valid_o),
        .store_wb_rob_o    (store_wb_rob_o),
        .mem_redirect_o    (mem_redirect_o)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic is_older(logic aw, logic [5:0] ai, logic bw, logic [5:0] bi);
        if (aw == bw) begin
            return ai < bi;
        end
        return ai > bi;
    endfunction

    function automatic logic [3:0] exp_mask(logic [1:0] size, logic [1:0] off);
        logic [3:0] m;
        case (size)
            2'b10: m = 4'b1111;
            2'b01: begin
                case (off)
                    2'd0: m = 4'b0011;
                    2'd1: m = 4'b0110;
                    2'd2: m = 4'b1100;
                    default: m = 4'b1000;
                endcase
            end
            default: begin
                case (off)
                    2'd0: m = 4'b0001;
                    2'd1: m = 4'b0010;
                    2'd2: m = 4'b0100;
                    default: m = 4'b1000;
                endcase
            end
        endcase
        return m;
    endfunction

    function automatic load_enq_t make_load(load_issue_t li);
        load_enq_t e;
        e.addr    = li.base + li.imm;
        e.mask    = exp_mask(li.size, e.addr[1:0]);
        e.lq_idx  = li.lq_idx;
        e.rob_idx = li.rob_idx;
        e.rd      = li.rd;
        return e;
    endfunction

    function automatic store_enq_t make_store(store_issue_t si);
        store_enq_t e;
        e.addr    = si.base + si.imm;
        e.mask    = exp_mask(si.size, e.addr[1:0]);
        e.rob_idx = si.rob_idx;
        return e;
    endfunction

    function automatic logic flushed(rob_idx_t r);
        return redirect_i.valid
            && is_older(redirect_i.rob_idx.wrap, redirect_i.rob_idx.idx, r.wrap, r.idx);
    endfunction

    function automatic logic conflicts(store_enq_t s, lq_idx_t slq, load_enq_t l);
        return (s.addr[31:2] == l.addr[31:2]) && ((s.mask & l.mask) != 4'b0000)
            && !is_older(l.lq_idx.wrap, {2'b00, l.lq_idx.idx}, slq.wrap, {2'b00, slq.idx});
    endfunction

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // reference model and output checks
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if (clk) begin
                check_val("load_enq_valid_o", 64'(0), 64'(load_enq_valid_o));
                check_val("store_enq_valid_o", 64'(0), 64'(store_enq_valid_o));
                check_val("store_wb_valid_o", 64'(0), 64'(store_wb_valid_o));
                check_val("mem_redirect_o.valid", 64'(0), 64'(mem_redirect_o.valid));
            end
            m_ld1_v <= '0;
            m_ld2_v <= '0;
            m_ld1   <= '0;
            m_ld2   <= '0;
            m_st1_v <= '0;
            m_st1   <= '0;
            m_st1_lq <= '0;
            m_wb_v  <= '0;
            m_wb_rob <= '0;
            m_red0  <= '0;
            m_red1  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                check_val($sformatf("load_enq_valid_o[%0d]", i),
                          64'(m_ld2_v[i] && !flushed(m_ld2[i].rob_idx)),
                          64'(load_enq_valid_o[i]));
                if (m_ld2_v[i] && !flushed(m_ld2[i].rob_idx)) begin
                    check_val($sformatf("load_enq_o[%0d]", i), 64'(m_ld2[i]), 64'(load_enq_o[i]));
                end
                check_val($sformatf("store_enq_valid_o[%0d]", i),
                          64'(m_st1_v[i] && !flushed(m_st1[i].rob_idx)),
                          64'(store_enq_valid_o[i]));
                if (m_st1_v[i] && !flushed(m_st1[i].rob_idx)) begin
                    check_val($sformatf("store_enq_o[%0d]", i), 64'(m_st1[i]),
                              64'(store_enq_o[i]));
                end
                check_val($sformatf("store_wb_valid_o[%0d]", i), 64'(m_wb_v[i]),
                          64'(store_wb_valid_o[i]));
                if (m_wb_v[i]) begin
                    check_val($sformatf("store_wb_rob_o[%0d]", i), 64'(m_wb_rob[i]),
                              64'(store_wb_rob_o[i]));
                end
            end
            check_val("mem_redirect_o.valid", 64'(m_red1.valid), 64'(mem_redirect_o.valid));
            if (m_red1.valid) begin
                check_val("mem_redirect_o.rob_idx", 64'(m_red1.rob_idx),
                          64'(mem_redirect_o.rob_idx));
            end
            if (mem_redirect_o.valid) begin
                red_seen++;
            end

            // oldest offending load over S1 and S2 against stores not yet flushed
            best_v   = 1'b0;
            best_lq  = '0;
            best_rob = '0;
            for (int s = 0; s < 2; s++) begin
                for (int j = 0; j < 4; j++) begin
                    cand   = j[1] ? m_ld2[j[0]] : m_ld1[j[0]];
                    cand_v = j[1] ? m_ld2_v[j[0]] : m_ld1_v[j[0]];
                    if (m_st1_v[s] && cand_v && conflicts(m_st1[s], m_st1_lq[s], cand)
                        && (!best_v || is_older(cand.lq_idx.wrap, {2'b00, cand.lq_idx.idx},
                                                best_lq.wrap, {2'b00, best_lq.idx}))) begin
                        best_v   = 1'b1;
                        best_lq  = cand.lq_idx;
                        best_rob = cand.rob_idx;
                    end
                end
            end
            m_red0.valid   <= best_v;
            m_red0.rob_idx <= best_rob;
            m_red1 <= m_red0;

            for (int i = 0; i < 2; i++) begin
                m_ld2_v[i]  <= m_ld1_v[i] && !flushed(m_ld1[i].rob_idx);
                m_ld2[i]    <= m_ld1[i];
                m_ld1_v[i]  <= load_valid_i[i] && !flushed(load_issue_i[i].rob_idx);
                m_ld1[i]    <= make_load(load_issue_i[i]);
                m_wb_v[i]   <= m_st1_v[i] && !flushed(m_st1[i].rob_idx);
                m_wb_rob[i] <= m_st1[i].rob_idx;
                m_st1_v[i]  <= store_valid_i[i] && !flushed(store_issue_i[i].rob_idx);
                m_st1[i]    <= make_store(store_issue_i[i]);
                m_st1_lq[i] <= store_issue_i[i].lq_idx;
            end
        end
    end

    task automatic idle_inputs();
        load_valid_i  = '0;
        store_valid_i = '0;
        redirect_i    = '0;
    endtask

    task automatic set_load(int lane, logic [31:0] base, logic [31:0] imm, logic [1:0] size,
                            logic [4:0] lq, logic [6:0] rob);
        load_valid_i[lane]         = 1'b1;
        load_issue_i[lane].base    = base;
        load_issue_i[lane].imm     = imm;
        load_issue_i[lane].size    = mem_size_t'(size);
        load_issue_i[lane].lq_idx  = lq;
        load_issue_i[lane].rob_idx = rob;
        load_issue_i[lane].rd      = 5'(rand_bits(5));
    endtask

    task automatic set_store(int lane, logic [31:0] base, logic [31:0] imm, logic [1:0] size,
                             logic [4:0] lq, logic [6:0] rob);
        store_valid_i[lane]         = 1'b1;
        store_issue_i[lane].base    = base;
        store_issue_i[lane].imm     = imm;
        store_issue_i[lane].size    = mem_size_t'(size);
        store_issue_i[lane].lq_idx  = lq;
        store_issue_i[lane].rob_idx = rob;
    endtask

    function automatic logic [1:0] rand_size();
        logic [1:0] sz;
        sz = 2'(rand_bits(2));
        return (sz == 2'd3) ? 2'd0 : sz;
    endfunction

    // top bit keeps loads and stores in separate regions
    function automatic logic [31:0] rand_base(logic top);
        return {top, 1'b0, 30'(rand_bits(30))};
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_redirect(logic [6:0] exp_rob);
        int n;
        n = 0;
        while (!mem_redirect_o.valid && n < 8) begin
            @(negedge clk);
            n++;
        end
        assert (mem_redirect_o.valid) else begin
            seq_errors++;
            $display("memory redirect for ROB index %h never arrived", exp_rob);
        end
        if (mem_redirect_o.valid) begin
            assert (mem_redirect_o.rob_idx === exp_rob) else begin
                seq_errors++;
                $display("ERROR %0t mem_redirect_o.rob_idx expected %h got %h", $time, exp_rob,
                         mem_redirect_o.rob_idx);
            end
        end
    endtask

    task automatic end_test(string name, int err_before);
        int n;
        n = errors + seq_errors - err_before;
        tests_run++;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, n);
        end
    endtask

    initial begin
        int e0;
        int seen;
        idle_inputs();
        load_issue_i  = '0;
        store_issue_i = '0;

        e0 = errors + seq_errors;
        while (arst_n_i !== 1'b1) begin
            @(negedge clk);
        end
        wait_cycles(3);
        end_test("reset", e0);

        e0 = errors + seq_errors;
        for (int c = 0; c < N_RAND; c++) begin
            @(negedge clk);
            idle_inputs();
            for (int l = 0; l < 2; l++) begin
                if (rand_bits(1) != 0) begin
                    set_load(l, rand_base(1'b0), rand_bits(12), rand_size(), 5'(rand_bits(5)),
                             7'(rand_bits(7)));
                end
            end
        end
        @(negedge clk);
        idle_inputs();
        wait_cycles(4);
        end_test("load address and mask", e0);

        e0 = errors + seq_errors;
        for (int c = 0; c < N_RAND; c++) begin
            @(negedge clk);
            idle_inputs();
            for (int l = 0; l < 2; l++) begin
                if (rand_bits(1) != 0) begin
                    set_store(l, rand_base(1'b1), rand_bits(12), rand_size(), 5'(rand_bits(5)),
                              7'(rand_bits(7)));
                end
            end
        end
        @(negedge clk);
        idle_inputs();
        wait_cycles(4);
        end_test("stores", e0);

        // lane 0 straddles the redirect index and lane 1 is all younger
        e0 = errors + seq_errors;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            idle_inputs();
            set_load(0, rand_base(1'b0), rand_bits(12), rand_size(), 5'(k), 7'(8 + k));
            set_load(1, rand_base(1'b0), rand_bits(12), rand_size(), 5'(k), 7'(20 + k));
            set_store(0, rand_base(1'b1), rand_bits(12), rand_size(), 5'(k), 7'(8 + k));
            set_store(1, rand_base(1'b1), rand_bits(12), rand_size(), 5'(k), 7'(20 + k));
            if (k == 3) begin
                redirect_i.valid   = 1'b1;
                redirect_i.rob_idx = 7'd10;
            end
        end
        @(negedge clk);
        idle_inputs();
        wait_cycles(5);
        end_test("redirect cancel", e0);

        e0 = errors + seq_errors;
        @(negedge clk);
        set_store(0, 32'h2000, 32'h4, 2'b10, 5'd5, 7'd30);
        set_load(0, 32'h2004, 32'h2, 2'b00, 5'd6, 7'd31);
        @(negedge clk);
        idle_inputs();
        wait_redirect(7'd31);
        wait_cycles(4);
        set_load(1, 32'h2100, 32'h0, 2'b01, 5'd7, 7'd33);
        @(negedge clk);
        idle_inputs();
        set_store(1, 32'h2100, 32'h1, 2'b00, 5'd6, 7'd32);
        @(negedge clk);
        idle_inputs();
        wait_redirect(7'd33);
        wait_cycles(4);
        seen = red_seen;
        set_store(0, 32'h2200, 32'h0, 2'b00, 5'd6, 7'd34);
        set_load(0, 32'h2201, 32'h0, 2'b00, 5'd7, 7'd35);
        set_store(1, 32'h2300, 32'h0, 2'b10, 5'd6, 7'd36);
        set_load(1, 32'h2304, 32'h0, 2'b10, 5'd7, 7'd37);
        @(negedge clk);
        idle_inputs();
        set_store(0, 32'h2400, 32'h0, 2'b10, 5'd6, 7'd38);
        set_load(0, 32'h2400, 32'h0, 2'b10, 5'd3, 7'd39);
        @(negedge clk);
        idle_inputs();
        wait_cycles(6);
        assert (red_seen == seen) else begin
            seq_errors++;
            $display("memory redirect raised for a pair that does not conflict");
        end
        end_test("violation detected", e0);

        e0 = errors + seq_errors;
        set_store(0, 32'h3000, 32'h0, 2'b10, 5'd8, 7'd40);
        set_store(1, 32'h3010, 32'h0, 2'b10, 5'd8, 7'd41);
        set_load(0, 32'h3000, 32'h0, 2'b10, 5'd12, 7'd50);
        set_load(1, 32'h3010, 32'h0, 2'b10, 5'd9, 7'd45);
        @(negedge clk);
        idle_inputs();
        wait_redirect(7'd45);
        wait_cycles(4);
        end_test("oldest selection", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors + seq_errors);
        if (errors + seq_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for 8 rising edges, released away from the edge
    initial begin
        arst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

/* violation/violation_check.sv */
`timescale 1ns/1ns

module violation_check (
    input  logic                                          clk,
    input  logic                                          arst_n_i,
    input  lsu_pkg::viol_rec_t [lsu_pkg::STORE_PIPES-1:0] store_rec_i,
    input  lsu_pkg::viol_rec_t [lsu_pkg::LOAD_PIPES-1:0]  load_s1_rec_i,
    input  lsu_pkg::viol_rec_t [lsu_pkg::LOAD_PIPES-1:0]  load_s2_rec_i,
    output lsu_pkg::redirect_t                            mem_redirect_o
);
    import lsu_pkg::*;

    viol_rec_t [STORE_PIPES-1:0][LOAD_PIPES-1:0] s1_hit;
    viol_rec_t [STORE_PIPES-1:0][LOAD_PIPES-1:0] s2_hit;
    viol_rec_t [STORE_PIPES-1:0] s1_sel;
    viol_rec_t [STORE_PIPES-1:0] s2_sel;
    viol_rec_t [STORE_PIPES-1:0] s1_sel_q;
    viol_rec_t [STORE_PIPES-1:0] s2_sel_q;
    viol_rec_t s1_oldest;
    viol_rec_t s2_oldest;
    viol_rec_t final_sel;
    viol_rec_t final_q;

    // load record with valid set when it ran ahead of the store
    function automatic viol_rec_t check(viol_rec_t st, viol_rec_t ld);
        viol_rec_t res;
        res = ld;
        res.valid = st.valid && ld.valid
            && (st.addr[ADDR_W-1:2] == ld.addr[ADDR_W-1:2])
            && (|(st.mask & ld.mask))
            && !lq_older(ld.lq_idx, st.lq_idx);
        return res;
    endfunction

    // keeps a on a tie or when b is empty
    function automatic viol_rec_t pick_older(viol_rec_t a, viol_rec_t b);
        logic take_a;
        take_a = a.valid && (!b.valid || !lq_older(b.lq_idx, a.lq_idx));
        return take_a ? a : b;
    endfunction

    always_comb begin
        for (int i = 0; i < STORE_PIPES; i++) begin
            for (int j = 0; j < LOAD_PIPES; j++) begin
                s1_hit[i][j] = check(store_rec_i[i], load_s1_rec_i[j]);
                s2_hit[i][j] = check(store_rec_i[i], load_s2_rec_i[j]);
            end
            s1_sel[i] = pick_older(s1_hit[i][0], s1_hit[i][1]);
            s2_sel[i] = pick_older(s2_hit[i][0], s2_hit[i][1]);
        end
    end

    // first stage, one winner per store
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_sel_q <= '0;
            s2_sel_q <= '0;
        end else begin
            s1_sel_q <= s1_sel;
            s2_sel_q <= s2_sel;
        end
    end

    // second stage, across stores and then across load stages
    assign s1_oldest = pick_older(s1_sel_q[0], s1_sel_q[1]);
    assign s2_oldest = pick_older(s2_sel_q[0], s2_sel_q[1]);
    assign final_sel = pick_older(s1_oldest, s2_oldest);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            final_q <= '0;
        end else begin
            final_q <= final_sel;
        end
    end

    assign mem_redirect_o.valid   = final_q.valid;
    assign mem_redirect_o.rob_idx = final_q.rob_idx;

endmodule
